//--- src/csr_pkg.sv
package csr_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [31:0]     instr_t;

    // implemented machine CSRs
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    // custom timer compare
    localparam csr_addr_t CSR_MTIMECMP = 12'h7C0;

    // major opcode, bits 6:2
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // full encodings of the two trap instructions
    localparam instr_t INSTR_ECALL = 32'h0000_0073;
    localparam instr_t INSTR_MRET  = 32'h3020_0073;

    localparam xlen_t MSTATUS_RESET = 64'h0000_0000_0000_1800;
    localparam logic [1:0] PRIV_M = 2'b11;

    localparam xlen_t CAUSE_ECALL_M = 64'd11;
    localparam xlen_t CAUSE_MTIMER  = 64'h8000_0000_0000_0007;

    // bit positions inside mstatus, mie and mip
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;
    localparam int MTI_BIT  = 7;

    typedef enum logic [1:0] {OP_NONE, OP_RW, OP_RS, OP_RC} csr_op_e;

    typedef enum logic [1:0] {TRAP_NONE, TRAP_ENTER, TRAP_RETURN} trap_cmd_e;

    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_RESP} fsm_state_e;

endpackage

//--- src/csr_access_if.sv
`timescale 1ns/1ns

interface csr_access_if;

    // request side, driven by the trap controller
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_t addr;
    csr_pkg::xlen_t     wdata;
    csr_pkg::xlen_t     pc;
    csr_pkg::trap_cmd_e trap_cmd;
    csr_pkg::xlen_t     cause;
    logic               strobe;

    // status side, driven by the register file
    csr_pkg::xlen_t     rdata;
    logic               addr_ok;
    csr_pkg::xlen_t     mtvec;
    csr_pkg::xlen_t     mepc;
    logic               irq_take;

    modport fsm (
        output op, addr, wdata, pc, trap_cmd, cause, strobe,
        input  rdata, addr_ok, mtvec, mepc, irq_take
    );

    modport regfile (
        input  op, addr, wdata, pc, trap_cmd, cause, strobe,
        output rdata, addr_ok, mtvec, mepc, irq_take
    );

endinterface

//--- src/csr_mtimer.sv
`timescale 1ns/1ns

module csr_mtimer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           tmr_we_i,
    input  csr_pkg::xlen_t tmr_wdata_i,
    output csr_pkg::xlen_t mcycle_o,
    output csr_pkg::xlen_t mtimecmp_o,
    output logic           mtip_o
);

    csr_pkg::xlen_t mcycle_q;
    csr_pkg::xlen_t mtimecmp_q;
    logic           mtip_q;

    // free-running cycle count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    // all ones keeps the timer quiet until software arms it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;
        end else if (tmr_we_i) begin
            mtimecmp_q <= tmr_wdata_i;
        end
    end

    // pending flag lags the compare by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtip_q <= 1'b0;
        end else begin
            mtip_q <= (mcycle_q >= mtimecmp_q);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign mtimecmp_o = mtimecmp_q;
    assign mtip_o     = mtip_q;

endmodule

//--- src/csr_regfile.sv
`timescale 1ns/1ns

module csr_regfile (
    input  logic           clk,
    input  logic           rst_n,
    csr_access_if.regfile  acc,
    input  csr_pkg::xlen_t mcycle_i,
    input  csr_pkg::xlen_t mtimecmp_i,
    input  logic           mtip_i,
    output logic           tmr_we_o,
    output csr_pkg::xlen_t tmr_wdata_o
);

    // mstatus keeps only its three live fields
    logic           st_mie;
    logic           st_mpie;
    logic [1:0]     st_mpp;

    csr_pkg::xlen_t mie_q;
    csr_pkg::xlen_t mtvec_q;
    csr_pkg::xlen_t mepc_q;
    csr_pkg::xlen_t mcause_q;

    csr_pkg::xlen_t mstatus_rd;
    csr_pkg::xlen_t mip_rd;
    csr_pkg::xlen_t rd_val;
    csr_pkg::xlen_t wr_val;
    logic           rd_ok;
    logic           wr_en;

    always_comb begin
        mstatus_rd                              = '0;
        mstatus_rd[csr_pkg::MIE_BIT]            = st_mie;
        mstatus_rd[csr_pkg::MPIE_BIT]           = st_mpie;
        mstatus_rd[csr_pkg::MPP_LSB +: 2]       = st_mpp;
    end

    // MTIP mirrors the timer, nothing is latched here
    always_comb begin
        mip_rd                   = '0;
        mip_rd[csr_pkg::MTI_BIT] = mtip_i;
    end

    always_comb begin
        rd_ok = 1'b1;
        case (acc.addr)
            csr_pkg::CSR_MSTATUS:  rd_val = mstatus_rd;
            csr_pkg::CSR_MIE:      rd_val = mie_q;
            csr_pkg::CSR_MTVEC:    rd_val = mtvec_q;
            csr_pkg::CSR_MEPC:     rd_val = mepc_q;
            csr_pkg::CSR_MCAUSE:   rd_val = mcause_q;
            csr_pkg::CSR_MIP:      rd_val = mip_rd;
            csr_pkg::CSR_MCYCLE:   rd_val = mcycle_i;
            csr_pkg::CSR_MTIMECMP: rd_val = mtimecmp_i;
            default: begin
                rd_val = '0;
                rd_ok  = 1'b0;
            end
        endcase
    end

    // read-modify-write result
    always_comb begin
        case (acc.op)
            csr_pkg::OP_RW: wr_val = acc.wdata;
            csr_pkg::OP_RS: wr_val = rd_val | acc.wdata;
            csr_pkg::OP_RC: wr_val = rd_val & ~acc.wdata;
            default:        wr_val = rd_val;
        endcase
    end

    assign wr_en = acc.strobe && (acc.op != csr_pkg::OP_NONE) && rd_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_mie   <= csr_pkg::MSTATUS_RESET[csr_pkg::MIE_BIT];
            st_mpie  <= csr_pkg::MSTATUS_RESET[csr_pkg::MPIE_BIT];
            st_mpp   <= csr_pkg::MSTATUS_RESET[csr_pkg::MPP_LSB +: 2];
            mie_q    <= '0;
            mtvec_q  <= '0;
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (acc.strobe) begin
            if (acc.trap_cmd == csr_pkg::TRAP_ENTER) begin
                mepc_q   <= {acc.pc[csr_pkg::XLEN-1:2], 2'b00};
                mcause_q <= acc.cause;
                st_mpie  <= st_mie;
                st_mie   <= 1'b0;
                st_mpp   <= csr_pkg::PRIV_M;
            end else if (acc.trap_cmd == csr_pkg::TRAP_RETURN) begin
                st_mie  <= st_mpie;
                st_mpie <= 1'b1;
            end else if (wr_en) begin
                case (acc.addr)
                    csr_pkg::CSR_MSTATUS: begin
                        st_mie  <= wr_val[csr_pkg::MIE_BIT];
                        st_mpie <= wr_val[csr_pkg::MPIE_BIT];
                        st_mpp  <= wr_val[csr_pkg::MPP_LSB +: 2];
                    end
                    csr_pkg::CSR_MIE:    mie_q    <= wr_val;
                    // direct mode only, low bits are hardwired
                    csr_pkg::CSR_MTVEC:  mtvec_q  <= {wr_val[csr_pkg::XLEN-1:2], 2'b00};
                    csr_pkg::CSR_MEPC:   mepc_q   <= {wr_val[csr_pkg::XLEN-1:2], 2'b00};
                    csr_pkg::CSR_MCAUSE: mcause_q <= wr_val;
                    // mip, mcycle read-only, mtimecmp lives in the timer
                    default: ;
                endcase
            end
        end
    end

    assign tmr_we_o    = wr_en && (acc.addr == csr_pkg::CSR_MTIMECMP);
    assign tmr_wdata_o = wr_val;

    assign acc.rdata    = rd_val;
    assign acc.addr_ok  = rd_ok;
    assign acc.mtvec    = mtvec_q;
    assign acc.mepc     = mepc_q;
    assign acc.irq_take = mtip_i && mie_q[csr_pkg::MTI_BIT] && st_mie;

endmodule

//--- src/csr_trap_fsm.sv
`timescale 1ns/1ns

module csr_trap_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::instr_t     instr_i,
    input  csr_pkg::xlen_t      rs1_data_i,
    output logic                ack_o,
    output csr_pkg::xlen_t      rd_data_o,
    output logic                redirect_o,
    output csr_pkg::xlen_t      redirect_pc_o,
    output logic                illegal_o,
    csr_access_if.fsm           acc
);

    csr_pkg::fsm_state_e state;
    csr_pkg::csr_op_e    op_q;
    csr_pkg::trap_cmd_e  trap_q;
    csr_pkg::csr_addr_t  addr_q;
    csr_pkg::xlen_t      wdata_q;
    csr_pkg::xlen_t      pc_q;
    csr_pkg::xlen_t      cause_q;
    logic                strobe_q;
    logic                bad_instr_q;

    logic [4:0]          opcode;
    logic [2:0]          funct3;
    logic                is_system;
    logic                is_ecall;
    logic                is_mret;
    csr_pkg::csr_op_e    dec_op;
    logic                take_req;
    logic                commit;

    assign opcode    = instr_i[6:2];
    assign funct3    = instr_i[14:12];
    assign is_system = (opcode == csr_pkg::OPC_SYSTEM);
    assign is_ecall  = (instr_i == csr_pkg::INSTR_ECALL);
    assign is_mret   = (instr_i == csr_pkg::INSTR_MRET);

    assign take_req = (state == csr_pkg::ST_IDLE) && req_i;
    // second EXEC cycle, the one with strobe high
    assign commit   = (state == csr_pkg::ST_EXEC) && strobe_q;

    always_comb begin
        dec_op = csr_pkg::OP_NONE;
        if (is_system) begin
            case (funct3)
                csr_pkg::F3_CSRRW: dec_op = csr_pkg::OP_RW;
                csr_pkg::F3_CSRRS: dec_op = csr_pkg::OP_RS;
                csr_pkg::F3_CSRRC: dec_op = csr_pkg::OP_RC;
                default:           dec_op = csr_pkg::OP_NONE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= csr_pkg::ST_IDLE;
            op_q        <= csr_pkg::OP_NONE;
            trap_q      <= csr_pkg::TRAP_NONE;
            strobe_q    <= 1'b0;
            bad_instr_q <= 1'b0;
            ack_o       <= 1'b0;
            redirect_o  <= 1'b0;
            illegal_o   <= 1'b0;
        end else begin
            case (state)
                csr_pkg::ST_IDLE: begin
                    if (req_i) begin
                        state <= csr_pkg::ST_EXEC;
                        if (acc.irq_take) begin
                            // pending timer wins, instruction is dropped
                            op_q        <= csr_pkg::OP_NONE;
                            trap_q      <= csr_pkg::TRAP_ENTER;
                            bad_instr_q <= 1'b0;
                        end else begin
                            op_q        <= dec_op;
                            if (is_ecall) begin
                                trap_q <= csr_pkg::TRAP_ENTER;
                            end else if (is_mret) begin
                                trap_q <= csr_pkg::TRAP_RETURN;
                            end else begin
                                trap_q <= csr_pkg::TRAP_NONE;
                            end
                            bad_instr_q <= (dec_op == csr_pkg::OP_NONE) && !is_ecall && !is_mret;
                        end
                    end
                end
                csr_pkg::ST_EXEC: begin
                    if (!strobe_q) begin
                        // first cycle lets the read mux settle on the latched addr
                        strobe_q <= 1'b1;
                    end else begin
                        strobe_q   <= 1'b0;
                        ack_o      <= 1'b1;
                        redirect_o <= (trap_q != csr_pkg::TRAP_NONE);
                        illegal_o  <= bad_instr_q ||
                                      ((op_q != csr_pkg::OP_NONE) && !acc.addr_ok);
                        state      <= csr_pkg::ST_RESP;
                    end
                end
                csr_pkg::ST_RESP: begin
                    // hold the response until the core lets go of req
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= csr_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= csr_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q  <= instr_i[31:20];
            wdata_q <= rs1_data_i;
            pc_q    <= pc_i;
            cause_q <= acc.irq_take ? csr_pkg::CAUSE_MTIMER : csr_pkg::CAUSE_ECALL_M;
        end
        if (commit) begin
            // old CSR value, sampled before the write lands
            rd_data_o <= (op_q != csr_pkg::OP_NONE) ? acc.rdata : '0;
            case (trap_q)
                csr_pkg::TRAP_ENTER:  redirect_pc_o <= acc.mtvec;
                csr_pkg::TRAP_RETURN: redirect_pc_o <= acc.mepc;
                default:              redirect_pc_o <= '0;
            endcase
        end
    end

    assign acc.op       = op_q;
    assign acc.addr     = addr_q;
    assign acc.wdata    = wdata_q;
    assign acc.pc       = pc_q;
    assign acc.trap_cmd = trap_q;
    assign acc.cause    = cause_q;
    assign acc.strobe   = strobe_q;

endmodule

//--- src/csr_unit_top.sv
`timescale 1ns/1ns

module csr_unit_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_i,
    input  csr_pkg::xlen_t  pc_i,
    input  csr_pkg::instr_t instr_i,
    input  csr_pkg::xlen_t  rs1_data_i,
    output logic            ack_o,
    output csr_pkg::xlen_t  rd_data_o,
    output logic            redirect_o,
    output csr_pkg::xlen_t  redirect_pc_o,
    output logic            illegal_o
);

    // timer link between regfile and timer
    logic           tmr_we;
    csr_pkg::xlen_t tmr_wdata;
    csr_pkg::xlen_t mcycle;
    csr_pkg::xlen_t mtimecmp;
    logic           mtip;

    csr_access_if acc_if ();

    csr_trap_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (req_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .ack_o         (ack_o),
        .rd_data_o     (rd_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .illegal_o     (illegal_o),
        .acc           (acc_if)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc         (acc_if),
        .mcycle_i    (mcycle),
        .mtimecmp_i  (mtimecmp),
        .mtip_i      (mtip),
        .tmr_we_o    (tmr_we),
        .tmr_wdata_o (tmr_wdata)
    );

    csr_mtimer u_mtimer (
        .clk         (clk),
        .rst_n       (rst_n),
        .tmr_we_i    (tmr_we),
        .tmr_wdata_i (tmr_wdata),
        .mcycle_o    (mcycle),
        .mtimecmp_o  (mtimecmp),
        .mtip_o      (mtip)
    );

endmodule

//--- test/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;

    logic            clk;
    logic            rst_n;
    logic            req_i;
    csr_pkg::xlen_t  pc_i;
    csr_pkg::instr_t instr_i;
    csr_pkg::xlen_t  rs1_data_i;
    logic            ack_o;
    csr_pkg::xlen_t  rd_data_o;
    logic            redirect_o;
    csr_pkg::xlen_t  redirect_pc_o;
    logic            illegal_o;

    // reference copies of the machine CSRs
    csr_pkg::xlen_t  m_mstatus;
    csr_pkg::xlen_t  m_mie;
    csr_pkg::xlen_t  m_mtvec;
    csr_pkg::xlen_t  m_mepc;
    csr_pkg::xlen_t  m_mcause;

    // response captured while ack_o is high
    csr_pkg::xlen_t  got_rd;
    logic            got_redir;
    csr_pkg::xlen_t  got_rpc;
    logic            got_ill;

    csr_unit_top UUT (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input csr_pkg::xlen_t exp,
                                   input csr_pkg::xlen_t act);
        abort_run($sformatf("MISMATCH %s expected %h actual %h", test, exp, act));
    endtask

    // ack only ever answers a request
    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack_o) |-> $past(req_i))
        else abort_run("ack_o rose without a request on req_i");

    // response is held while the core keeps req high
    assert property (@(posedge clk) disable iff (!rst_n) (ack_o && req_i) |=> ack_o)
        else abort_run("ack_o dropped while req_i was still high");

    function automatic csr_pkg::xlen_t rand_pc();
        return {$urandom(), $urandom()} & ~64'h3;
    endfunction

    // csrrx with rs1 = x1, rd = x2
    function automatic csr_pkg::instr_t csr_instr(input logic [2:0] f3,
                                                  input csr_pkg::csr_addr_t a);
        return {a, 5'd1, f3, 5'd2, 7'b1110011};
    endfunction

    function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t a);
        case (a)
            csr_pkg::CSR_MSTATUS: return m_mstatus;
            csr_pkg::CSR_MIE:     return m_mie;
            csr_pkg::CSR_MTVEC:   return m_mtvec;
            csr_pkg::CSR_MEPC:    return m_mepc;
            csr_pkg::CSR_MCAUSE:  return m_mcause;
            default:              return '0;
        endcase
    endfunction

    function automatic void model_write(input csr_pkg::csr_addr_t a, input csr_pkg::xlen_t v);
        case (a)
            // only MIE, MPIE and MPP live in mstatus
            csr_pkg::CSR_MSTATUS: m_mstatus = v & 64'h1888;
            csr_pkg::CSR_MIE:     m_mie = v;
            csr_pkg::CSR_MTVEC:   m_mtvec = v & ~64'h3;
            csr_pkg::CSR_MEPC:    m_mepc = v & ~64'h3;
            csr_pkg::CSR_MCAUSE:  m_mcause = v;
            default: ;
        endcase
    endfunction

    function automatic void model_enter(input csr_pkg::xlen_t cause, input csr_pkg::xlen_t pc);
        m_mepc         = pc;
        m_mcause       = cause;
        m_mstatus[7]   = m_mstatus[3];
        m_mstatus[3]   = 1'b0;
        m_mstatus[12:11] = 2'b11;
    endfunction

    function automatic void model_return();
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
    endfunction

    // one full four-phase transaction, req held one cycle past ack
    task automatic run_instr(input csr_pkg::xlen_t pc, input csr_pkg::instr_t ins,
                             input csr_pkg::xlen_t rs1);
        int waited;
        @(negedge clk);
        pc_i       = pc;
        instr_i    = ins;
        rs1_data_i = rs1;
        req_i      = 1'b1;
        waited     = 0;
        while (!ack_o) begin
            @(negedge clk);
            waited++;
            if (waited > 20) abort_run("timeout waiting for ack_o to rise");
        end
        // sampled at edge N, ack at N+2, seen on the third falling edge
        assert (waited == 3) else report_mismatch("latency", 64'd3, csr_pkg::xlen_t'(waited));
        got_rd    = rd_data_o;
        got_redir = redirect_o;
        got_rpc   = redirect_pc_o;
        got_ill   = illegal_o;
        @(negedge clk);
        req_i  = 1'b0;
        waited = 0;
        while (ack_o) begin
            @(negedge clk);
            waited++;
            if (waited > 20) abort_run("timeout waiting for ack_o to fall");
        end
    endtask

    task automatic csr_access(input string name, input logic [2:0] f3,
                              input csr_pkg::csr_addr_t a, input csr_pkg::xlen_t operand);
        csr_pkg::xlen_t old;
        csr_pkg::xlen_t nv;
        old = model_read(a);
        run_instr(rand_pc(), csr_instr(f3, a), operand);
        assert (got_rd == old) else report_mismatch(name, old, got_rd);
        assert (!got_redir && !got_ill)
            else abort_run($sformatf("%s: unexpected redirect or illegal flag", name));
        if (f3 == csr_pkg::F3_CSRRW) nv = operand;
        else if (f3 == csr_pkg::F3_CSRRS) nv = old | operand;
        else nv = old & ~operand;
        model_write(a, nv);
    endtask

    task automatic check_all(input string name);
        csr_access({name, "_mstatus"}, csr_pkg::F3_CSRRS, csr_pkg::CSR_MSTATUS, '0);
        csr_access({name, "_mie"}, csr_pkg::F3_CSRRS, csr_pkg::CSR_MIE, '0);
        csr_access({name, "_mtvec"}, csr_pkg::F3_CSRRS, csr_pkg::CSR_MTVEC, '0);
        csr_access({name, "_mepc"}, csr_pkg::F3_CSRRS, csr_pkg::CSR_MEPC, '0);
        csr_access({name, "_mcause"}, csr_pkg::F3_CSRRS, csr_pkg::CSR_MCAUSE, '0);
    endtask

    task automatic trap_instr(input string name, input csr_pkg::instr_t ins,
                              input csr_pkg::xlen_t pc, input csr_pkg::xlen_t rs1,
                              input csr_pkg::xlen_t target);
        run_instr(pc, ins, rs1);
        assert (got_redir) else abort_run($sformatf("%s: redirect_o not set", name));
        assert (got_rpc == target) else report_mismatch(name, target, got_rpc);
        assert (got_rd == '0) else report_mismatch({name, "_rd"}, '0, got_rd);
        assert (!got_ill) else abort_run($sformatf("%s: illegal_o set on a trap", name));
    endtask

    initial begin
        csr_pkg::csr_addr_t a;
        logic [2:0]         f3;
        csr_pkg::xlen_t     pc;
        csr_pkg::xlen_t     cyc;
        int                 tries;

        void'($urandom(32'hc3af366e));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_i      = 1'b0;
        pc_i       = '0;
        instr_i    = '0;
        rs1_data_i = '0;
        m_mstatus  = 64'h1800;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        check_all("reset");

        // random read-modify-write traffic
        for (int i = 0; i < 24; i++) begin
            case ($urandom_range(3, 0))
                0: a = csr_pkg::CSR_MTVEC;
                1: a = csr_pkg::CSR_MEPC;
                2: a = csr_pkg::CSR_MCAUSE;
                default: a = csr_pkg::CSR_MIE;
            endcase
            case ($urandom_range(2, 0))
                0: f3 = csr_pkg::F3_CSRRW;
                1: f3 = csr_pkg::F3_CSRRS;
                default: f3 = csr_pkg::F3_CSRRC;
            endcase
            csr_access("rmw", f3, a, {$urandom(), $urandom()});
        end
        check_all("rmw_readback");

        // ecall and mret, first with MIE set, then with MPIE cleared
        csr_access("ecall_setup", csr_pkg::F3_CSRRS, csr_pkg::CSR_MSTATUS, 64'h8);
        pc = rand_pc();
        trap_instr("ecall", 32'h0000_0073, pc, '0, m_mtvec);
        model_enter(64'd11, pc);
        check_all("ecall");
        trap_instr("mret", 32'h3020_0073, rand_pc(), '0, m_mepc);
        model_return();
        check_all("mret");
        trap_instr("ecall2", 32'h0000_0073, pc, '0, m_mtvec);
        model_enter(64'd11, pc);
        csr_access("mret_setup", csr_pkg::F3_CSRRC, csr_pkg::CSR_MSTATUS, 64'h80);
        trap_instr("mret2", 32'h3020_0073, rand_pc(), '0, m_mepc);
        model_return();
        check_all("mret2");
        // entry with MIE clear leaves MPIE clear
        pc = rand_pc();
        trap_instr("ecall3", 32'h0000_0073, pc, '0, m_mtvec);
        model_enter(64'd11, pc);
        check_all("ecall3");

        // timer: arm with MIE off, wait for pending, then enable
        csr_access("tmr_mie_off", csr_pkg::F3_CSRRC, csr_pkg::CSR_MSTATUS, 64'h8);
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MCYCLE), '0);
        cyc = got_rd;
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MTIMECMP), cyc + 30);
        assert (got_rd == '1) else report_mismatch("mtimecmp_reset", '1, got_rd);
        csr_access("tmr_mtie", csr_pkg::F3_CSRRS, csr_pkg::CSR_MIE, 64'h80);
        tries = 0;
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MIP), '0);
        while (got_rd[7] !== 1'b1) begin
            tries++;
            if (tries > 40) abort_run("timeout waiting for mip.MTIP to be set");
            run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MIP), '0);
        end
        csr_access("tmr_mie_on", csr_pkg::F3_CSRRS, csr_pkg::CSR_MSTATUS, 64'h8);
        pc = rand_pc();
        trap_instr("timer_irq", csr_instr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MCAUSE), pc,
                   {$urandom(), $urandom()}, m_mtvec);
        // the mcause write of the dropped instruction must not land
        model_enter(64'h8000_0000_0000_0007, pc);
        check_all("timer_irq");

        // unknown CSR address
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRW, 12'h7FF), {$urandom(), $urandom()});
        assert (got_ill) else abort_run("unknown CSR address did not set illegal_o");
        assert (got_rd == '0) else report_mismatch("bad_addr_rd", '0, got_rd);
        // mcycle ignores writes
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MCYCLE), '0);
        cyc = got_rd;
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRW, csr_pkg::CSR_MCYCLE),
                  {$urandom(), $urandom()});
        assert (!got_ill) else abort_run("write to mcycle set illegal_o");
        run_instr(rand_pc(), csr_instr(csr_pkg::F3_CSRRS, csr_pkg::CSR_MCYCLE), '0);
        assert (got_rd > cyc && got_rd - cyc < 64)
            else abort_run($sformatf("mcycle changed by a write, %h then %h", cyc, got_rd));
        // addi is not a SYSTEM instruction
        run_instr(rand_pc(), 32'h0010_0093, {$urandom(), $urandom()});
        assert (got_ill) else abort_run("non-SYSTEM instruction did not set illegal_o");
        assert (got_rd == '0) else report_mismatch("non_system_rd", '0, got_rd);
        assert (!got_redir) else abort_run("non-SYSTEM instruction set redirect_o");
        check_all("illegal");

        $display("No errors");
        $finish;
    end

endmodule

//--- sources.f
src/csr_pkg.sv
src/csr_access_if.sv
src/csr_mtimer.sv
src/csr_regfile.sv
src/csr_trap_fsm.sv
src/csr_unit_top.sv
test/csr_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= csr_unit_tb
RTL_TOP   ?= csr_unit_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
